// File: verilog/usrt_pkg.sv
/* Synchronous receiver definitions */

`default_nettype none

package usrt_pkg;

   ////////////////////////////////////////
   // Widths
   ////////////////////////////////////////

   // One serial character
   typedef logic [7:0]  char_t;
   // Raw status shifter, two characters deep
   typedef logic [15:0] stat_sr_t;
   // Bit position within a character
   typedef logic [2:0]  bitcnt_t;
   // APB offset and data
   typedef logic [3:0]  apb_addr_t;
   typedef logic [15:0] apb_data_t;
   // Idle bit counter
   typedef logic [5:0]  idle_t;

   ////////////////////////////////////////
   // Register map
   ////////////////////////////////////////

   localparam apb_addr_t ADDR_CSR   = 4'h0;
   localparam apb_addr_t ADDR_SYN   = 4'h4;
   localparam apb_addr_t ADDR_RXBUF = 4'h8;

   // CSR bit positions
   localparam int CSR_ENABLE  = 0;
   localparam int CSR_DECMODE = 1;
   localparam int CSR_IE      = 2;
   localparam int CSR_STAT_LO = 8;

   ////////////////////////////////////////
   // Line protocol
   ////////////////////////////////////////

   // SDLC flag 01111110
   localparam char_t FLAG_CHAR  = 8'b0111_1110;
   // Eight ones, SDLC abort
   localparam char_t ABORT_CHAR = 8'b1111_1111;
   // Ones in a row before a stuffed zero
   localparam int    STUFF_ONES = 5;
   // Bit times without a character before timeout
   localparam idle_t IDLE_BITS  = 6'd48;

   // Receive states
   typedef enum logic [1:0] {
      RX_OFF,
      RX_HUNT,
      RX_FRAME
   } rx_state_e;

   // Receive events, MSB first, done lands on CSR bit 8
   typedef struct packed {
      logic synced;
      logic timeout;
      logic abort;
      logic eof;
      logic overrun;
      logic done;
   } rx_status_t;

   localparam int STAT_W = $bits(rx_status_t);

endpackage

`default_nettype wire

// File: verilog/usrt_bit_timer.sv
/* Receive bit timer */

`default_nettype none

module usrt_bit_timer (
   input  logic clk,
   input  logic rst,
   input  logic rxc,
   input  logic rxd,
   input  logic rx_clr,
   input  logic char_done,
   output logic bit_en,
   output logic rxd_s,
   output logic idle_exp
);
   import usrt_pkg::*;

   logic [1:0] rxc_sync;
   logic [1:0] rxd_sync;
   logic       rxc_last;
   idle_t      idle_cnt;

   // Two-flop synchronizers, rxd rides with rxc
   // Third stage of rxd lines up with the strobe below
   always_ff @(posedge clk)
   begin
      rxc_sync <= {rxc_sync[0], rxc};
      rxd_sync <= {rxd_sync[0], rxd};
      rxd_s    <= rxd_sync[1];
   end

   // Rising edge of the synchronized rxc
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         // Modem clock idles high, no false edge out of reset
         rxc_last <= 1'b1;
         bit_en   <= 1'b0;
      end
      else
      begin
         rxc_last <= rxc_sync[1];
         bit_en   <= rxc_sync[1] & ~rxc_last;
      end
   end

   // Idle timer
   // Counts bit times, saturates at IDLE_BITS, one pulse on arrival
   always_ff @(posedge clk)
   begin
      if (rst || rx_clr || char_done)
      begin
         idle_cnt <= '0;
         idle_exp <= 1'b0;
      end
      else if (bit_en && idle_cnt != IDLE_BITS)
      begin
         idle_cnt <= idle_cnt + 1'b1;
         idle_exp <= (idle_cnt == IDLE_BITS - 1'b1);
      end
      else
         idle_exp <= 1'b0;
   end

endmodule

`default_nettype wire

// File: verilog/usrt_rx.sv
/* Serial receiver and character framer */

`default_nettype none

module usrt_rx (
   input  logic            clk,
   input  logic            rst,
   input  logic            rx_clr,
   input  logic            bit_en,
   input  logic            decmode,
   input  logic            rxd_s,
   input  usrt_pkg::char_t synchr,
   output logic            full,
   output logic            flag,
   output logic            abort,
   output logic            sync,
   output usrt_pkg::char_t data
);
   import usrt_pkg::*;

   stat_sr_t   stat;
   logic [2:0] ones;
   bitcnt_t    bitcnt;
   logic       valid;
   logic       special;
   logic       zbd;
   logic       syn_pair;
   logic       fill;

   ////////////////////////////////////////
   // Shift registers
   ////////////////////////////////////////

   // Raw status shifter, never has bits deleted
   // Newest bit enters at the top, LSB first on the line
   always_ff @(posedge clk)
   begin
      if (rst || rx_clr)
         stat <= '0;
      else if (bit_en)
         stat <= {rxd_s, stat[15:1]};
   end

   // Data shifter, stuffed zeros skipped
   always_ff @(posedge clk)
   begin
      if (bit_en && !zbd)
         data <= {rxd_s, data[7:1]};
   end

   ////////////////////////////////////////
   // Special characters
   ////////////////////////////////////////

   // Flag and abort exist only in SDLC mode
   assign flag  = !decmode && (stat[15:8] == FLAG_CHAR);
   assign abort = !decmode && (stat[15:8] == ABORT_CHAR);

   // Two SYN characters back to back
   assign syn_pair = (stat == {synchr, synchr});

   // Character sync for either mode
   assign sync = decmode ? syn_pair : flag;

   // Last eight bits formed a flag or abort
   // So the bit now arriving follows one directly
   assign special = flag || abort;

   ////////////////////////////////////////
   // Zero-bit deletion
   ////////////////////////////////////////

   // Consecutive ones, saturates so long mark runs do not wrap
   always_ff @(posedge clk)
   begin
      if (rst || rx_clr)
         ones <= '0;
      else if (bit_en)
      begin
         if (!rxd_s)
            ones <= '0;
         else if (ones != 3'd7)
            ones <= ones + 1'b1;
      end
   end

   // Drop the bit after five ones, SDLC only
   assign zbd = !decmode && !special && (ones == STUFF_ONES);

   ////////////////////////////////////////
   // Character framing
   ////////////////////////////////////////

   // Bit position, sync puts the current bit at position 1
   always_ff @(posedge clk)
   begin
      if (rst || rx_clr)
         bitcnt <= '0;
      else if (bit_en)
      begin
         if (sync)
            bitcnt <= bitcnt_t'(1);
         else if (!zbd)
            bitcnt <= bitcnt + 1'b1;
      end
   end

   // Set by the first sync, held until cleared
   always_ff @(posedge clk)
   begin
      if (rst || rx_clr)
         valid <= 1'b0;
      else if (bit_en && sync)
         valid <= 1'b1;
   end

   // DDCMP mark fill, all ones on an idle line, is not a character
   assign fill = decmode && (data == ABORT_CHAR);

   // Character complete, holds for one bit time
   assign full = valid && (bitcnt == '0) && !fill;

endmodule

`default_nettype wire

// File: verilog/usrt_rx_fsm.sv
/* Receive state machine */

`default_nettype none

module usrt_rx_fsm (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 enable,
   input  logic                 bit_en,
   input  logic                 full,
   input  logic                 flag,
   input  logic                 abort,
   input  logic                 sync,
   input  logic                 idle_exp,
   input  usrt_pkg::char_t      data,
   output logic                 rx_clr,
   output logic                 char_done,
   output usrt_pkg::char_t      rx_char,
   output usrt_pkg::rx_status_t events
);
   import usrt_pkg::*;

   rx_state_e  state;
   rx_state_e  state_next;
   logic       bit_en_d;
   logic       store;
   rx_status_t ev;

   // Receiver outputs settle one cycle after the strobe
   always_ff @(posedge clk)
   begin
      if (rst)
         bit_en_d <= 1'b0;
      else
         bit_en_d <= bit_en;
   end

   always_comb
   begin
      state_next = state;
      ev         = '0;
      rx_clr     = (state == RX_OFF);
      char_done  = 1'b0;
      store      = 1'b0;
      // Dropping enable stops the receiver from any state
      if (!enable)
         state_next = RX_OFF;
      else
      begin
         case (state)
            RX_OFF:
               state_next = RX_HUNT;
            RX_HUNT:
               if (bit_en_d && sync)
               begin
                  ev.synced  = 1'b1;
                  char_done  = 1'b1;
                  state_next = RX_FRAME;
               end
            RX_FRAME:
               if (bit_en_d && abort)
               begin
                  // Frame thrown away, hunt for a new flag
                  ev.abort   = 1'b1;
                  rx_clr     = 1'b1;
                  state_next = RX_HUNT;
               end
               else if (bit_en_d && full)
               begin
                  char_done = 1'b1;
                  // Closing flag is not a character
                  if (flag)
                     ev.eof = 1'b1;
                  else
                  begin
                     ev.done = 1'b1;
                     store   = 1'b1;
                  end
               end
               else if (idle_exp)
               begin
                  ev.timeout = 1'b1;
                  rx_clr     = 1'b1;
                  state_next = RX_HUNT;
               end
            default:
               state_next = RX_OFF;
         endcase
      end
   end

   // State and event pulses
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state  <= RX_OFF;
         events <= '0;
      end
      else
      begin
         state  <= state_next;
         events <= ev;
      end
   end

   // Character goes out with its done pulse
   always_ff @(posedge clk)
   begin
      if (store)
         rx_char <= data;
   end

endmodule

`default_nettype wire

// File: verilog/usrt_regs.sv
/* APB register file */

`default_nettype none

module usrt_regs (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  usrt_pkg::apb_addr_t  paddr,
   input  usrt_pkg::apb_data_t  pwdata,
   output usrt_pkg::apb_data_t  prdata,
   input  usrt_pkg::rx_status_t events,
   input  usrt_pkg::char_t      rx_char,
   output logic                 enable,
   output logic                 decmode,
   output usrt_pkg::char_t      synchr,
   output logic                 irq
);
   import usrt_pkg::*;

   logic       wr;
   logic       rd;
   logic       csr_wr;
   logic       rxbuf_rd;
   logic       ie;
   char_t      rxbuf;
   rx_status_t stat;
   rx_status_t stat_set;
   rx_status_t stat_clr;

   ////////////////////////////////////////
   // Access decode
   ////////////////////////////////////////

   // Access phase commits at the end of the cycle
   assign wr       = psel && penable && pwrite;
   assign rd       = psel && penable && !pwrite;
   assign csr_wr   = wr && (paddr == ADDR_CSR);
   assign rxbuf_rd = rd && (paddr == ADDR_RXBUF);

   // Control bits
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         enable  <= 1'b0;
         decmode <= 1'b0;
         ie      <= 1'b0;
      end
      else if (csr_wr)
      begin
         enable  <= pwdata[CSR_ENABLE];
         decmode <= pwdata[CSR_DECMODE];
         ie      <= pwdata[CSR_IE];
      end
   end

   // SYN character for DDCMP sync
   always_ff @(posedge clk)
   begin
      if (rst)
         synchr <= '0;
      else if (wr && paddr == ADDR_SYN)
         synchr <= pwdata[7:0];
   end

   // Receive buffer is overwritten on every done
   always_ff @(posedge clk)
   begin
      if (rst)
         rxbuf <= '0;
      else if (events.done)
         rxbuf <= rx_char;
   end

   ////////////////////////////////////////
   // Sticky status
   ////////////////////////////////////////

   always_comb
   begin
      stat_set = events;
      // New character while the old one is unread
      stat_set.overrun = events.done && stat.done && !rxbuf_rd;
      stat_clr = '0;
      // Write one to clear
      if (csr_wr)
         stat_clr = pwdata[CSR_STAT_LO +: STAT_W];
      // Reading the buffer also clears done
      if (rxbuf_rd)
         stat_clr.done = 1'b1;
   end

   // A new event wins over a clear in the same cycle
   always_ff @(posedge clk)
   begin
      if (rst)
         stat <= '0;
      else
         stat <= (stat & ~stat_clr) | stat_set;
   end

   // Interrupt on a character waiting
   always_ff @(posedge clk)
   begin
      if (rst)
         irq <= 1'b0;
      else
         irq <= stat.done && ie;
   end

   // Combinational read mux so data is valid in the access cycle
   always_comb
   begin
      prdata = '0;
      case (paddr)
         ADDR_CSR:
         begin
            prdata[CSR_ENABLE]              = enable;
            prdata[CSR_DECMODE]             = decmode;
            prdata[CSR_IE]                  = ie;
            prdata[CSR_STAT_LO +: STAT_W]   = stat;
         end
         ADDR_SYN:
            prdata = apb_data_t'(synchr);
         ADDR_RXBUF:
            prdata = apb_data_t'(rxbuf);
         default:
            prdata = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/usrt_rx_top.sv
/* Synchronous receiver top */

`default_nettype none

module usrt_rx_top (
   input  logic                clk,
   input  logic                rst,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  usrt_pkg::apb_addr_t paddr,
   input  usrt_pkg::apb_data_t pwdata,
   output usrt_pkg::apb_data_t prdata,
   input  logic                rxc,
   input  logic                rxd,
   output logic                irq
);
   import usrt_pkg::*;

   // Bit timer outputs
   logic       bit_en;
   logic       rxd_s;
   logic       idle_exp;
   // Receiver to FSM
   logic       full;
   logic       flag;
   logic       abort;
   logic       sync;
   char_t      data;
   // FSM outputs
   logic       rx_clr;
   logic       char_done;
   char_t      rx_char;
   rx_status_t events;
   // Control from the registers
   logic       enable;
   logic       decmode;
   char_t      synchr;

   usrt_bit_timer u_timer (
      .clk       (clk),
      .rst       (rst),
      .rxc       (rxc),
      .rxd       (rxd),
      .rx_clr    (rx_clr),
      .char_done (char_done),
      .bit_en    (bit_en),
      .rxd_s     (rxd_s),
      .idle_exp  (idle_exp)
   );

   usrt_rx u_rx (
      .clk     (clk),
      .rst     (rst),
      .rx_clr  (rx_clr),
      .bit_en  (bit_en),
      .decmode (decmode),
      .rxd_s   (rxd_s),
      .synchr  (synchr),
      .full    (full),
      .flag    (flag),
      .abort   (abort),
      .sync    (sync),
      .data    (data)
   );

   usrt_rx_fsm u_fsm (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .bit_en    (bit_en),
      .full      (full),
      .flag      (flag),
      .abort     (abort),
      .sync      (sync),
      .idle_exp  (idle_exp),
      .data      (data),
      .rx_clr    (rx_clr),
      .char_done (char_done),
      .rx_char   (rx_char),
      .events    (events)
   );

   usrt_regs u_regs (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .events  (events),
      .rx_char (rx_char),
      .enable  (enable),
      .decmode (decmode),
      .synchr  (synchr),
      .irq     (irq)
   );

endmodule

`default_nettype wire

// File: test/usrt_rx_asserts.sv
/* Receiver FSM assertions */

`default_nettype none

module usrt_rx_asserts (
   input  logic                 clk,
   input  logic                 rst,
   input  usrt_pkg::rx_state_e  state,
   input  logic                 rx_clr,
   input  usrt_pkg::rx_status_t events
);
   timeunit 1ns;
   timeprecision 100ps;
   import usrt_pkg::*;

   // Flat copy of the event bus
   logic [STAT_W-1:0] ev_bits;
   // Failed checks, read back at the end of the run
   int                fail_count = 0;

   assign ev_bits = events;

   ////////////////////////////////////////
   // Event bus
   ////////////////////////////////////////

   // At most one event per cycle
   a_events_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ev_bits))
      else
      begin
         fail_count = fail_count + 1;
         $error("More than one receive event in the same cycle");
      end

   ////////////////////////////////////////
   // State machine
   ////////////////////////////////////////

   // Reset parks the receiver
   a_reset_off: assert property (@(posedge clk) rst |=> (state == RX_OFF))
      else
      begin
         fail_count = fail_count + 1;
         $error("Receive state is not RX_OFF after reset");
      end

   // Receiver held clear while off
   a_off_clear: assert property (@(posedge clk) disable iff (rst) (state == RX_OFF) |-> rx_clr)
      else
      begin
         fail_count = fail_count + 1;
         $error("rx_clr is low in RX_OFF");
      end

endmodule

bind usrt_rx_fsm usrt_rx_asserts u_asserts (
   .clk    (clk),
   .rst    (rst),
   .state  (state),
   .rx_clr (rx_clr),
   .events (events)
);

`default_nettype wire

// File: test/usrt_rx_tb.sv
/* Synchronous receiver testbench */

`default_nettype none

module usrt_rx_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import usrt_pkg::*;

   // Clock cycles allowed for any wait
   localparam int WAIT_LIMIT = 5000;

   logic      clk;
   logic      rst;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   apb_data_t pwdata;
   apb_data_t prdata;
   logic      rxc;
   logic      rxd;
   logic      irq;

   // Line side bookkeeping
   logic      sdlc_mode;
   int        line_ones;
   int        bit_period;
   int        fd;
   int        code;
   string     line;

   usrt_rx_top DUT (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .rxc     (rxc),
      .rxd     (rxd),
      .irq     (irq)
   );

   // 100 ns clock
   always #50 clk = ~clk;

   task automatic stop_with_failure(input string what);
      $display("%s", what);
      $display("Finished with errors");
      $fatal(1, "Simulation stopped");
   endtask

   ////////////////////////////////////////
   // APB master
   ////////////////////////////////////////

   task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
      @(negedge clk);
      psel    = 1'b1;
      pwrite  = 1'b1;
      penable = 1'b0;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      // Stuffing follows the line mode
      if (addr == ADDR_CSR)
         sdlc_mode = !data[CSR_DECMODE];
   endtask

   task automatic apb_read_check(input apb_addr_t addr, input apb_data_t exp);
      apb_data_t got;
      @(negedge clk);
      psel    = 1'b1;
      pwrite  = 1'b0;
      penable = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      // prdata settles well before the commit edge
      #10;
      got = prdata;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      assert (got === exp)
      else
         stop_with_failure($sformatf("[ERROR] %0t ns: read at %h gave %h, expected %h",
                                     $time, addr, got, exp));
   endtask

   ////////////////////////////////////////
   // Serial line
   ////////////////////////////////////////

   // One bit per rxc period with data moving while rxc is low
   task automatic send_bit(input logic b);
      int low;
      int high;
      low  = bit_period / 2;
      high = bit_period - low;
      @(negedge clk);
      rxc = 1'b0;
      repeat (2) @(negedge clk);
      rxd = b;
      repeat (low - 2) @(negedge clk);
      rxc = 1'b1;
      repeat (high - 1) @(negedge clk);
      line_ones = b ? line_ones + 1 : 0;
   endtask

   // Sends LSB first with optional zero insertion after five ones
   task automatic send_byte(input char_t value, input logic stuff);
      for (int i = 0; i < 8; i++)
      begin
         send_bit(value[i]);
         if (stuff && line_ones == STUFF_ONES)
            send_bit(1'b0);
      end
   endtask

   task automatic wait_irq(input logic level);
      int cycles;
      cycles = 0;
      while (irq !== level && cycles < WAIT_LIMIT)
      begin
         @(negedge clk);
         cycles++;
      end
      assert (irq === level)
      else
         stop_with_failure($sformatf("Timed out waiting for irq to go to %0d", level));
   endtask

   ////////////////////////////////////////
   // Pattern commands
   ////////////////////////////////////////

   task automatic run_command(input string text);
      byte       cmd;
      string     rest;
      apb_data_t a;
      apb_data_t b;
      int        n;
      int        nargs;
      a     = '0;
      b     = '0;
      n     = 0;
      nargs = 0;
      cmd   = text.getc(0);
      rest  = text.substr(1, text.len() - 1);
      // New rxc rate for every command
      bit_period = 6 + int'($urandom % 7);
      case (cmd)
         "W", "R":
         begin
            nargs = $sscanf(rest, "%h %h", a, b);
            if (nargs != 2)
               stop_with_failure($sformatf("Pattern line is malformed: %s", text));
            if (cmd == "W")
               apb_write(a[3:0], b);
            else
               apb_read_check(a[3:0], b);
         end
         "B", "S":
         begin
            nargs = $sscanf(rest, "%h", a);
            send_byte(a[7:0], (cmd == "B") && sdlc_mode);
         end
         "F":
            send_byte(FLAG_CHAR, 1'b0);
         "A":
            send_byte(ABORT_CHAR, 1'b0);
         "I":
         begin
            nargs = $sscanf(rest, "%d", n);
            repeat (n) send_bit(1'b1);
         end
         "Q":
         begin
            nargs = $sscanf(rest, "%h", a);
            wait_irq(a[0]);
         end
         "#", "\n", "\r", " ":
            nargs = 0;
         default:
            stop_with_failure($sformatf("Unknown pattern command in line: %s", text));
      endcase
      // Let the last strobe reach the status register
      repeat (8) @(negedge clk);
   endtask

   initial
   begin
      clk         = 1'b0;
      rst         = 1'b1;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      rxc         = 1'b1;
      rxd         = 1'b1;
      sdlc_mode   = 1'b1;
      line_ones   = 0;
      bit_period  = 8;
      void'($urandom(32'he8de));
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      fd = $fopen("test/usrt_rx_patterns.txt", "r");
      if (fd == 0)
         stop_with_failure("Could not open the pattern file");
      while (!$feof(fd))
      begin
         code = $fgets(line, fd);
         if (code > 0)
            run_command(line);
      end
      $fclose(fd);
      // Bound checks count their own failures
      if (DUT.u_fsm.u_asserts.fail_count == 0)
      begin
         $display("Finished with no errors");
         $finish;
      end
      else
      begin
         $display("Finished with errors");
         $fatal(1, "Simulation stopped");
      end
   end

endmodule

`default_nettype wire

// File: test/usrt_rx_patterns.txt
# W addr data | R addr expected | B/S byte | F | A | I bits (decimal) | Q irq level
# All numbers hex except the I count; CSR=0 SYN=4 RXBUF=8
R 0 0000
W 0 0001
F
B 3E
R 0 2101
R 8 003E
B FF
R 8 00FF
B 5A
R 8 005A
I 1
F
R 0 2401
W 0 3F00
W 4 0096
W 0 0003
S 96
S 96
B 7C
R 8 007C
B 1F
R 0 2103
R 8 001F
R 0 2003
I 50
R 0 3003
W 0 3F00
R 0 0000
W 0 0001
F
B 42
R 8 0042
A
B CC
R 0 2801
W 0 3F01
R 0 0001
F
B 11
B 22
R 0 2301
R 8 0022
W 0 3F05
R 0 0005
B 33
Q 1
R 0 0105
R 8 0033
Q 0
I 1
F
R 0 0405
W 0 0405
R 0 0005
W 0 0000
R 0 0000

// File: src.f
verilog/usrt_pkg.sv
verilog/usrt_bit_timer.sv
verilog/usrt_rx.sv
verilog/usrt_rx_fsm.sv
verilog/usrt_regs.sv
verilog/usrt_rx_top.sv
test/usrt_rx_asserts.sv
test/usrt_rx_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f \
   --top-module usrt_rx_tb -o usrt_rx_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/usrt_rx_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -q "Finished with no errors"; then
   exit 0
fi
exit 1
